// File: logic/fc8_pkg.sv
package fc8_pkg;

    localparam int PHYS_AW = 20;
    localparam int CPU_AW  = 16;
    localparam int DATA_W  = 8;
    localparam int PAGE_W  = 5;
    localparam int RAM_AW  = 15;
    localparam int VRAM_AW = 16;

    // Physical memory map
    localparam logic [PHYS_AW-1:0] RAM_BASE      = 20'h00000;
    localparam logic [PHYS_AW-1:0] RAM_END       = 20'h07FFF;
    localparam logic [PHYS_AW-1:0] RESV_BASE     = 20'h08000;
    localparam logic [PHYS_AW-1:0] RESV_END      = 20'h0FFFF;
    localparam logic [PHYS_AW-1:0] VRAM_BASE     = 20'h10000;
    localparam logic [PHYS_AW-1:0] VRAM_END      = 20'h1FFFF;
    localparam logic [PHYS_AW-1:0] SFR_BASE      = 20'h20000;
    localparam logic [PHYS_AW-1:0] SFR_END       = 20'h2FFFF;
    localparam logic [PHYS_AW-1:0] CART_BASE     = 20'h30000;
    localparam logic [PHYS_AW-1:0] CART_END      = 20'hFFFFF;
    localparam logic [PHYS_AW-1:0] PAGE_SEL_ADDR = 20'h000FE; // Sits inside work RAM

    localparam logic [DATA_W-1:0] OPEN_BUS = 8'hFF;

    // SFR offsets from SFR_BASE
    localparam logic [15:0] SFR_SCROLL_X    = 16'h0009;
    localparam logic [15:0] SFR_SCROLL_Y    = 16'h000B;
    localparam logic [15:0] SFR_SCREEN_CTRL = 16'h0021;
    localparam logic [15:0] SFR_RAND        = 16'h0024;
    localparam logic [15:0] SFR_TIMER_CTRL  = 16'h0028;
    localparam logic [15:0] SFR_TIMER_LO    = 16'h0029;
    localparam logic [15:0] SFR_TIMER_HI    = 16'h002A;
    localparam logic [15:0] SFR_INT_EN      = 16'h002B;
    localparam logic [15:0] SFR_INT_STAT    = 16'h002C;
    localparam logic [15:0] SFR_VSYNC       = 16'h0033;
    localparam logic [15:0] SFR_FRAME_LO    = 16'h0034;
    localparam logic [15:0] SFR_FRAME_HI    = 16'h0035;
    localparam logic [15:0] SFR_PAD1        = 16'h0600;
    localparam logic [15:0] SFR_PAD2        = 16'h0601;
    localparam logic [15:0] SFR_PAD_CONN    = 16'h0602;

    localparam int IRQ_TIMER_BIT = 0;

    typedef struct packed {
        logic [CPU_AW-1:0] addr;
        logic [DATA_W-1:0] wdata;
        logic              we;
    } cpu_bus_t;

    // Flat view for decode, paged view for translation
    typedef union packed {
        logic [PHYS_AW-1:0] raw;
        struct packed {
            logic [PAGE_W-1:0]         page;
            logic [PHYS_AW-PAGE_W-1:0] offset;
        } paged;
    } fc8_phys_addr_u;

    typedef struct packed {
        logic page_reg;
        logic ram;
        logic resv;
        logic vram;
        logic sfr;
        logic cart;
    } fc8_region_t;

    typedef struct packed {
        logic [DATA_W-1:0] screen_ctrl;
        logic [DATA_W-1:0] scroll_x;
        logic [DATA_W-1:0] scroll_y;
    } gfx_ctrl_t;

    typedef struct packed {
        logic [1:0] vsync;     // Bit 0 level, bit 1 pulse
        logic       frame_inc;
    } gfx_status_t;

    typedef struct packed {
        logic [DATA_W-1:0] pad1;
        logic [DATA_W-1:0] pad2;
        logic              conn1;
        logic              conn2;
    } pad_in_t;

endpackage

// File: logic/fc8_bank_mapper.sv
`timescale 1ns/1ps

module fc8_bank_mapper
    import fc8_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  cpu_bus_t          cpu,
    output fc8_phys_addr_u    phys,
    output fc8_region_t       region,
    output logic [DATA_W-1:0] page_sel
);

    function automatic logic in_range(
        input logic [PHYS_AW-1:0] addr,
        input logic [PHYS_AW-1:0] lo,
        input logic [PHYS_AW-1:0] hi
    );
        return (addr >= lo) && (addr <= hi);
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            page_sel <= '0;
        end else if (cpu.we && region.page_reg) begin
            page_sel <= cpu.wdata;
        end
    end

    // Upper half of the logical space is banked
    always_comb begin
        phys.paged.offset = cpu.addr[RAM_AW-1:0];
        if (cpu.addr[CPU_AW-1]) begin
            phys.paged.page = page_sel[PAGE_W-1:0];
        end else begin
            phys.paged.page = '0;
        end
    end

    always_comb begin
        region.page_reg = (phys.raw == PAGE_SEL_ADDR);
        region.ram      = !region.page_reg && in_range(phys.raw, RAM_BASE, RAM_END);
        region.resv     = in_range(phys.raw, RESV_BASE, RESV_END);
        region.vram     = in_range(phys.raw, VRAM_BASE, VRAM_END);
        region.sfr      = in_range(phys.raw, SFR_BASE, SFR_END);
        region.cart     = in_range(phys.raw, CART_BASE, CART_END);
    end

endmodule

// File: logic/fc8_work_ram.sv
`timescale 1ns/1ps

module fc8_work_ram
    import fc8_pkg::*;
(
    input  logic              clk,
    input  logic              we,
    input  logic [RAM_AW-1:0] addr,
    input  logic [DATA_W-1:0] wdata,
    output logic [DATA_W-1:0] rdata
);

    logic [DATA_W-1:0] mem [0:(2**RAM_AW)-1];

    // Power-up contents are all zero
    initial begin
        for (int i = 0; i < 2**RAM_AW; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
    end

    assign rdata = mem[addr]; // Async read, top registers it

endmodule

// File: logic/fc8_vram.sv
`timescale 1ns/1ps

module fc8_vram
    import fc8_pkg::*;
(
    input  logic               clk,
    input  logic               we,
    input  logic [VRAM_AW-1:0] cpu_addr,
    input  logic [DATA_W-1:0]  wdata,
    output logic [DATA_W-1:0]  cpu_rdata,
    input  logic [VRAM_AW-1:0] gfx_addr,
    output logic [DATA_W-1:0]  gfx_rdata
);

    logic [DATA_W-1:0] mem [0:(2**VRAM_AW)-1];

    initial begin
        for (int i = 0; i < 2**VRAM_AW; i++) begin
            mem[i] = '0;
        end
    end

    // CPU port
    always_ff @(posedge clk) begin
        if (we) begin
            mem[cpu_addr] <= wdata;
        end
    end

    assign cpu_rdata = mem[cpu_addr];

    // Graphics port, one cycle latency
    always_ff @(posedge clk) begin
        gfx_rdata <= mem[gfx_addr];
    end

endmodule

// File: logic/fc8_sys_timer.sv
`timescale 1ns/1ps

module fc8_sys_timer
    import fc8_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                enable,
    output logic [2*DATA_W-1:0] count,
    output logic                overflow
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (enable) begin
            count <= count + 1'b1; // Wraps to zero after all ones
        end else begin
            count <= '0;
        end
    end

    // High for the cycle before the wrap, so the status bit sets on the wrap edge
    assign overflow = enable && (count == '1);

endmodule

// File: logic/fc8_sfr_block.sv
`timescale 1ns/1ps

module fc8_sfr_block
    import fc8_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  cpu_bus_t            cpu,
    input  logic                sel,
    input  logic [15:0]         offset,
    input  gfx_status_t         gfx_status,
    input  pad_in_t             pads,
    input  logic [2*DATA_W-1:0] timer_count,
    input  logic                timer_overflow,
    output logic                timer_enable,
    output gfx_ctrl_t           gfx_ctrl,
    output logic                timer_irq,
    output logic [DATA_W-1:0]   rdata
);

    logic                wr;
    logic                rd;
    logic [DATA_W-1:0]   timer_ctrl;
    logic [DATA_W-1:0]   int_en;
    logic [DATA_W-1:0]   int_stat;
    logic [DATA_W-1:0]   int_stat_next;
    logic [DATA_W-1:0]   lfsr;
    logic                lfsr_fb;
    logic [1:0]          vsync;
    logic [1:0]          conn;
    logic [2*DATA_W-1:0] frame_cnt;
    logic [DATA_W-1:0]   frame_hi_latch;

    assign wr = sel && cpu.we;
    assign rd = sel && !cpu.we;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            gfx_ctrl   <= '0;
            timer_ctrl <= '0;
            int_en     <= '0;
        end else if (wr) begin
            case (offset)
                SFR_SCREEN_CTRL: gfx_ctrl.screen_ctrl <= cpu.wdata;
                SFR_SCROLL_X:    gfx_ctrl.scroll_x    <= cpu.wdata;
                SFR_SCROLL_Y:    gfx_ctrl.scroll_y    <= cpu.wdata;
                SFR_TIMER_CTRL:  timer_ctrl           <= cpu.wdata;
                SFR_INT_EN:      int_en               <= cpu.wdata;
                default: ;
            endcase
        end
    end

    // Write 1 to clear, a new overflow wins over a clear in the same cycle
    always_comb begin
        int_stat_next = int_stat;
        if (wr && (offset == SFR_INT_STAT)) begin
            int_stat_next = int_stat & ~cpu.wdata;
        end
        if (timer_overflow) begin
            int_stat_next[IRQ_TIMER_BIT] = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            int_stat <= '0;
        end else begin
            int_stat <= int_stat_next;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vsync          <= '0;
            conn           <= '0;
            frame_cnt      <= '0;
            frame_hi_latch <= '0;
        end else begin
            vsync[0] <= gfx_status.vsync[0];
            if (gfx_status.vsync[1]) begin
                vsync[1] <= 1'b1;                 // Keep a pulse that lands on a read
            end else if (rd && (offset == SFR_VSYNC)) begin
                vsync[1] <= 1'b0;
            end
            conn <= {pads.conn2, pads.conn1};
            if (gfx_status.frame_inc) begin
                frame_cnt <= frame_cnt + 1'b1;
            end
            if (rd && (offset == SFR_FRAME_LO)) begin
                frame_hi_latch <= frame_cnt[2*DATA_W-1:DATA_W];
            end
        end
    end

    // Taps 0, 3, 4, 5
    assign lfsr_fb = lfsr[0] ^ lfsr[3] ^ lfsr[4] ^ lfsr[5];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lfsr <= 8'hA5;
        end else if (wr && (offset == SFR_RAND)) begin
            lfsr <= cpu.wdata;
        end else begin
            lfsr <= {lfsr_fb, lfsr[DATA_W-1:1]};
        end
    end

    assign timer_enable = timer_ctrl[0];
    assign timer_irq    = int_stat[IRQ_TIMER_BIT] & int_en[IRQ_TIMER_BIT];

    always_comb begin
        case (offset)
            SFR_SCREEN_CTRL: rdata = gfx_ctrl.screen_ctrl;
            SFR_SCROLL_X:    rdata = gfx_ctrl.scroll_x;
            SFR_SCROLL_Y:    rdata = gfx_ctrl.scroll_y;
            SFR_RAND:        rdata = lfsr;
            SFR_TIMER_CTRL:  rdata = timer_ctrl;
            SFR_TIMER_LO:    rdata = timer_count[DATA_W-1:0];
            SFR_TIMER_HI:    rdata = timer_count[2*DATA_W-1:DATA_W];
            SFR_INT_EN:      rdata = int_en;
            SFR_INT_STAT:    rdata = int_stat;
            SFR_VSYNC:       rdata = {{(DATA_W-2){1'b0}}, vsync};
            SFR_FRAME_LO:    rdata = frame_cnt[DATA_W-1:0];
            SFR_FRAME_HI:    rdata = frame_hi_latch;
            SFR_PAD1:        rdata = pads.pad1;         // Live pad state
            SFR_PAD2:        rdata = pads.pad2;
            SFR_PAD_CONN:    rdata = {{(DATA_W-2){1'b0}}, conn};
            default:         rdata = OPEN_BUS;
        endcase
    end

endmodule

// File: logic/fc8_memory_controller.sv
`timescale 1ns/1ps

module fc8_memory_controller
    import fc8_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  cpu_bus_t           cpu,
    input  logic [DATA_W-1:0]  cart_rom_data,
    input  logic [VRAM_AW-1:0] vram_gfx_addr,
    output logic [DATA_W-1:0]  vram_gfx_data,
    output gfx_ctrl_t          gfx_ctrl,
    input  gfx_status_t        gfx_status,
    input  pad_in_t            pads,
    output logic               timer_irq,
    output logic [DATA_W-1:0]  cpu_data_out,
    output logic [PHYS_AW-1:0] phys_addr
);

    fc8_phys_addr_u      phys;
    fc8_region_t         region;
    logic [DATA_W-1:0]   page_sel;
    logic [DATA_W-1:0]   ram_rdata;
    logic [DATA_W-1:0]   vram_rdata;
    logic [DATA_W-1:0]   sfr_rdata;
    logic [DATA_W-1:0]   read_byte;
    logic [PHYS_AW-1:0]  sfr_rel;
    logic [2*DATA_W-1:0] timer_count;
    logic                timer_overflow;
    logic                timer_enable;

    fc8_bank_mapper u_bank_mapper (
        .clk      (clk),
        .rst_n    (rst_n),
        .cpu      (cpu),
        .phys     (phys),
        .region   (region),
        .page_sel (page_sel)
    );

    fc8_work_ram u_work_ram (
        .clk   (clk),
        .we    (region.ram && cpu.we),
        .addr  (phys.paged.offset),
        .wdata (cpu.wdata),
        .rdata (ram_rdata)
    );

    fc8_vram u_vram (
        .clk       (clk),
        .we        (region.vram && cpu.we),
        .cpu_addr  (phys.raw[VRAM_AW-1:0]),
        .wdata     (cpu.wdata),
        .cpu_rdata (vram_rdata),
        .gfx_addr  (vram_gfx_addr),
        .gfx_rdata (vram_gfx_data)
    );

    fc8_sys_timer u_sys_timer (
        .clk      (clk),
        .rst_n    (rst_n),
        .enable   (timer_enable),
        .count    (timer_count),
        .overflow (timer_overflow)
    );

    assign sfr_rel = phys.raw - SFR_BASE;

    fc8_sfr_block u_sfr_block (
        .clk            (clk),
        .rst_n          (rst_n),
        .cpu            (cpu),
        .sel            (region.sfr),
        .offset         (sfr_rel[15:0]),
        .gfx_status     (gfx_status),
        .pads           (pads),
        .timer_count    (timer_count),
        .timer_overflow (timer_overflow),
        .timer_enable   (timer_enable),
        .gfx_ctrl       (gfx_ctrl),
        .timer_irq      (timer_irq),
        .rdata          (sfr_rdata)
    );

    // Region flags are one-hot, page register sits on top of RAM
    always_comb begin
        if (cpu.we || region.resv) begin
            read_byte = OPEN_BUS;
        end else if (region.page_reg) begin
            read_byte = page_sel;
        end else if (region.ram) begin
            read_byte = ram_rdata;
        end else if (region.vram) begin
            read_byte = vram_rdata;
        end else if (region.sfr) begin
            read_byte = sfr_rdata;
        end else if (region.cart) begin
            read_byte = cart_rom_data;
        end else begin
            read_byte = OPEN_BUS;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cpu_data_out <= '0;
        end else begin
            cpu_data_out <= read_byte;
        end
    end

    assign phys_addr = phys.raw;

endmodule

// File: verification/tb_fc8_memory_controller.sv
`timescale 1ns/1ps

module tb_fc8_memory_controller
    import fc8_pkg::*;
();

    logic               clk;
    logic               rst_n;
    cpu_bus_t           cpu;
    logic [DATA_W-1:0]  cart_rom_data;
    logic [VRAM_AW-1:0] vram_gfx_addr;
    logic [DATA_W-1:0]  vram_gfx_data;
    gfx_ctrl_t          gfx_ctrl;
    gfx_status_t        gfx_status;
    pad_in_t            pads;
    logic               timer_irq;
    logic [DATA_W-1:0]  cpu_data_out;
    logic [PHYS_AW-1:0] phys_addr;

    integer         seed;
    int             errors;
    int             checks;
    int             tests;
    int             test_err_start;
    string          cur_test;
    fc8_phys_addr_u last_phys; // Physical address seen during the last read

    fc8_memory_controller u_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .cpu           (cpu),
        .cart_rom_data (cart_rom_data),
        .vram_gfx_addr (vram_gfx_addr),
        .vram_gfx_data (vram_gfx_data),
        .gfx_ctrl      (gfx_ctrl),
        .gfx_status    (gfx_status),
        .pads          (pads),
        .timer_irq     (timer_irq),
        .cpu_data_out  (cpu_data_out),
        .phys_addr     (phys_addr)
    );

    always #4 clk = ~clk;

    task automatic bus_idle();
        cpu.addr  = '0;  // Plain RAM read, no side effects
        cpu.wdata = '0;
        cpu.we    = 1'b0;
    endtask

    task automatic cpu_write(input logic [CPU_AW-1:0] addr, input logic [DATA_W-1:0] data);
        @(negedge clk);
        cpu.addr  = addr;
        cpu.wdata = data;
        cpu.we    = 1'b1;
        @(posedge clk);
        @(negedge clk);
        bus_idle();
    endtask

    task automatic cpu_read(input logic [CPU_AW-1:0] addr, output logic [DATA_W-1:0] data);
        @(negedge clk);
        cpu.addr  = addr;
        cpu.wdata = '0;
        cpu.we    = 1'b0;
        @(posedge clk);
        @(negedge clk);
        data          = cpu_data_out;
        last_phys.raw = phys_addr;
        bus_idle();
    endtask

    task automatic select_page(input logic [PAGE_W-1:0] page);
        cpu_write(PAGE_SEL_ADDR[CPU_AW-1:0], {{(DATA_W-PAGE_W){1'b0}}, page});
    endtask

    // SFR accesses go through the banked half, so the SFR page must be selected
    task automatic sfr_write(input logic [15:0] offset, input logic [DATA_W-1:0] data);
        cpu_write({1'b1, offset[RAM_AW-1:0]}, data);
    endtask

    task automatic sfr_read(input logic [15:0] offset, output logic [DATA_W-1:0] data);
        cpu_read({1'b1, offset[RAM_AW-1:0]}, data);
    endtask

    task automatic check_byte(input string what, input logic [DATA_W-1:0] exp,
                              input logic [DATA_W-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error %s: %s expected %h, actual %h", cur_test, what, exp, act);
        end
    endtask

    task automatic check_addr(input string what, input fc8_phys_addr_u exp,
                              input fc8_phys_addr_u act);
        checks++;
        if (act.raw !== exp.raw) begin
            errors++;
            $display("** Error %s: %s expected %h, actual %h", cur_test, what, exp.raw, act.raw);
        end
    endtask

    task automatic check_gfx(input string what, input gfx_ctrl_t exp, input gfx_ctrl_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error %s: %s expected %h, actual %h", cur_test, what, exp, act);
        end
    endtask

    task automatic check_nonzero(input string what, input logic [DATA_W-1:0] act);
        checks++;
        if (act === '0 || $isunknown(act)) begin
            errors++;
            $display("%s: %s read as zero or unknown where a nonzero value was due",
                     cur_test, what);
        end
    endtask

    task automatic begin_test(input string name);
        cur_test       = name;
        test_err_start = errors;
        tests++;
    endtask

    task automatic end_test();
        $display("%s finished with %0d error(s)", cur_test, errors - test_err_start);
    endtask

    task automatic reset_values();
        logic [DATA_W-1:0] data;
        begin_test("reset_values");
        check_byte("cpu_data_out", 8'h00, cpu_data_out);
        check_gfx("gfx_ctrl", '0, gfx_ctrl);
        check_byte("timer_irq", 8'h00, {7'b0, timer_irq});
        cpu_read(PAGE_SEL_ADDR[CPU_AW-1:0], data);
        check_byte("page select", 8'h00, data);
        select_page(SFR_BASE[PHYS_AW-1:RAM_AW]);
        sfr_read(SFR_INT_EN, data);
        check_byte("int enable", 8'h00, data);
        sfr_read(SFR_INT_STAT, data);
        check_byte("int status", 8'h00, data);
        sfr_read(SFR_RAND, data);
        check_nonzero("lfsr", data);
        end_test();
    endtask

    task automatic ram_and_paging();
        logic [CPU_AW-1:0] addrs [8];
        logic [DATA_W-1:0] vals [8];
        logic [DATA_W-1:0] data;
        logic [CPU_AW-1:0] la;
        logic [DATA_W-1:0] cart_val;
        fc8_phys_addr_u    exp_phys;
        begin_test("ram_and_paging");
        for (int i = 0; i < 8; i++) begin
            la       = $random(seed);
            addrs[i] = {1'b0, i[2:0], la[11:0]}; // Distinct by top bits
            if (addrs[i] == PAGE_SEL_ADDR[CPU_AW-1:0]) begin
                addrs[i] = addrs[i] ^ 16'h0001;
            end
            vals[i] = $random(seed);
            cpu_write(addrs[i], vals[i]);
        end
        for (int i = 0; i < 8; i++) begin
            cpu_read(addrs[i], data);
            check_byte("ram readback", vals[i], data);
        end
        select_page(5'd3);
        la = 16'h8000 | ($random(seed) & 16'h7FFF);
        cpu_read(la, data);
        exp_phys.raw = 20'd3 * 20'h08000 + {5'd0, la[RAM_AW-1:0]};
        check_addr("paged phys_addr", exp_phys, last_phys);
        select_page(RESV_BASE[PHYS_AW-1:RAM_AW]);
        cpu_read(16'h8000 | ($random(seed) & 16'h7FFF), data);
        check_byte("reserved read", 8'hFF, data);
        cart_val      = $random(seed);
        cart_rom_data = cart_val;
        select_page(5'd7);
        cpu_read(16'h8000 | ($random(seed) & 16'h7FFF), data);
        check_byte("cartridge read", cart_val, data);
        end_test();
    endtask

    task automatic vram_ports();
        logic [PAGE_W-1:0]  pg [4];
        logic [RAM_AW-1:0]  off [4];
        logic [VRAM_AW-1:0] idx [4];
        logic [DATA_W-1:0]  vals [4];
        logic [DATA_W-1:0]  data;
        logic [PHYS_AW-1:0] phys;
        logic [15:0]        rnd;
        begin_test("vram_ports");
        for (int i = 0; i < 4; i++) begin
            rnd     = $random(seed);
            pg[i]   = VRAM_BASE[PHYS_AW-1:RAM_AW] + PAGE_W'(i % 2);
            off[i]  = {i[1:0], rnd[12:0]};
            phys    = 20'(pg[i]) * 20'h08000 + 20'(off[i]);
            idx[i]  = VRAM_AW'(phys - VRAM_BASE);
            vals[i] = $random(seed);
            select_page(pg[i]);
            cpu_write({1'b1, off[i]}, vals[i]);
        end
        for (int i = 0; i < 4; i++) begin
            select_page(pg[i]);
            cpu_read({1'b1, off[i]}, data);
            check_byte("vram cpu readback", vals[i], data);
            @(negedge clk);
            vram_gfx_addr = idx[i];
            @(posedge clk);
            @(negedge clk);
            check_byte("vram gfx readback", vals[i], vram_gfx_data);
        end
        end_test();
    endtask

    task automatic gfx_status_sfrs();
        gfx_ctrl_t         exp_gfx;
        logic [DATA_W-1:0] data;
        int                frames;
        pad_in_t           pad_val;
        begin_test("gfx_status_sfrs");
        exp_gfx = $random(seed);
        select_page(SFR_BASE[PHYS_AW-1:RAM_AW]);
        sfr_write(SFR_SCREEN_CTRL, exp_gfx.screen_ctrl);
        sfr_write(SFR_SCROLL_X, exp_gfx.scroll_x);
        sfr_write(SFR_SCROLL_Y, exp_gfx.scroll_y);
        check_gfx("gfx_ctrl", exp_gfx, gfx_ctrl);
        @(negedge clk);
        gfx_status.vsync = 2'b11;          // Level high plus a one-cycle pulse
        @(negedge clk);
        gfx_status.vsync = 2'b01;
        sfr_read(SFR_VSYNC, data);
        check_byte("vsync first read", 8'h03, data);
        sfr_read(SFR_VSYNC, data);
        check_byte("vsync second read", 8'h01, data);
        gfx_status.vsync = 2'b00;
        frames = 300;
        @(negedge clk);
        gfx_status.frame_inc = 1'b1;
        repeat (frames) @(negedge clk);
        gfx_status.frame_inc = 1'b0;
        sfr_read(SFR_FRAME_LO, data);
        check_byte("frame low", frames[7:0], data);
        sfr_read(SFR_FRAME_HI, data);
        check_byte("frame high", frames[15:8], data);
        pad_val = $random(seed);
        pads    = pad_val;
        sfr_read(SFR_PAD1, data);
        check_byte("pad1", pad_val.pad1, data);
        sfr_read(SFR_PAD2, data);
        check_byte("pad2", pad_val.pad2, data);
        sfr_read(SFR_PAD_CONN, data);
        check_byte("pad connection", {6'b0, pad_val.conn2, pad_val.conn1}, data);
        end_test();
    endtask

    task automatic timer_interrupt();
        logic [DATA_W-1:0] data;
        int                cycles;
        begin_test("timer_interrupt");
        select_page(SFR_BASE[PHYS_AW-1:RAM_AW]);
        sfr_write(SFR_INT_EN, 8'h01);
        sfr_write(SFR_TIMER_CTRL, 8'h01);
        cycles = 0;
        while (timer_irq !== 1'b1 && cycles < 70000) begin
            @(negedge clk);
            cycles++;
        end
        checks++;
        if (timer_irq !== 1'b1) begin
            errors++;
            $display("%s: timer_irq did not rise within 70000 cycles", cur_test);
        end else begin
            sfr_read(SFR_INT_STAT, data);
            check_byte("int status after overflow", 8'h01, data);
            sfr_write(SFR_INT_STAT, 8'h01);
            check_byte("timer_irq after clear", 8'h00, {7'b0, timer_irq});
        end
        sfr_write(SFR_TIMER_CTRL, 8'h00);
        sfr_read(SFR_TIMER_LO, data);
        check_byte("timer low when disabled", 8'h00, data);
        sfr_read(SFR_TIMER_HI, data);
        check_byte("timer high when disabled", 8'h00, data);
        end_test();
    endtask

    task automatic lfsr_behavior();
        logic [DATA_W-1:0] data;
        logic [DATA_W-1:0] lfsr_seed;
        begin_test("lfsr_behavior");
        select_page(SFR_BASE[PHYS_AW-1:RAM_AW]);
        sfr_write(SFR_RAND, 8'h00);
        sfr_read(SFR_RAND, data);
        check_byte("lfsr after zero load", 8'h00, data);
        lfsr_seed = $random(seed);
        lfsr_seed = lfsr_seed | 8'h01;     // Any nonzero state never reaches zero
        sfr_write(SFR_RAND, lfsr_seed);
        for (int i = 0; i < 4; i++) begin
            sfr_read(SFR_RAND, data);
            check_nonzero("lfsr after seed", data);
        end
        end_test();
    endtask

    initial begin
        seed           = 32'hbdd9;
        errors         = 0;
        checks         = 0;
        tests          = 0;
        test_err_start = 0;
        clk            = 1'b0;
        rst_n          = 1'b0;
        bus_idle();
        cart_rom_data  = '0;
        vram_gfx_addr  = '0;
        gfx_status     = '0;
        pads           = '0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        reset_values();
        ram_and_paging();
        vram_ports();
        gfx_status_sfrs();
        timer_interrupt();
        lfsr_behavior();

        $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: sim.f
logic/fc8_pkg.sv
logic/fc8_bank_mapper.sv
logic/fc8_work_ram.sv
logic/fc8_vram.sv
logic/fc8_sys_timer.sv
logic/fc8_sfr_block.sv
logic/fc8_memory_controller.sv
verification/tb_fc8_memory_controller.sv

// File: Bender.yml
package:
  name: fc8_memory_controller

sources:
  - files:
      - logic/fc8_pkg.sv
      - logic/fc8_bank_mapper.sv
      - logic/fc8_work_ram.sv
      - logic/fc8_vram.sv
      - logic/fc8_sys_timer.sv
      - logic/fc8_sfr_block.sv
      - logic/fc8_memory_controller.sv
  - target: simulation
    files:
      - verification/tb_fc8_memory_controller.sv
